// File: source/carTraffic.sv
// Moves the four car lanes sideways, once per frame tick
// A tick sampled at one edge shows up on o_Cars at that same edge
// Speeds stay below TileSize, so one subtract of ScreenWidth always wraps
`timescale 1ns/1ps

module carTraffic
(
    input  logic                       i_Clk,
    input  logic                       i_rstN,
    input  logic                       i_FrameTick,
    output frogGeometryPkg::carLanes_t o_Cars
);

    import frogGeometryPkg::*;

    // Current and next X of each lane
    xPos_t carX  [LaneCount];
    xPos_t nextX [LaneCount];
    xPos_t sumX  [LaneCount];

    ////////////////////////////////////////////////////////////
    // Next position with wrap at the right edge
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        for (int l = 0; l < LaneCount; l++)
        begin
            // Max sum is 639 + 5, still inside 10 bits
            sumX[l] = carX[l] + LaneSpeed[l];
            if (sumX[l] >= xPos_t'(ScreenWidth))
            begin
                nextX[l] = sumX[l] - xPos_t'(ScreenWidth);
            end
            else
            begin
                nextX[l] = sumX[l];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Lane registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_rstN)
    begin
        if (!i_rstN)
        begin
            for (int l = 0; l < LaneCount; l++)
            begin
                carX[l] <= CarStartX[l];
            end
        end
        else if (i_FrameTick)
        begin
            // Every lane steps together so the frame stays consistent
            for (int l = 0; l < LaneCount; l++)
            begin
                carX[l] <= nextX[l];
            end
        end
    end

    // Pack the lanes onto the car bus
    assign o_Cars.carX0 = carX[0];
    assign o_Cars.carX1 = carX[1];
    assign o_Cars.carX2 = carX[2];
    assign o_Cars.carX3 = carX[3];

endmodule

// File: source/collisionDetector.sv
// Box-overlap test between the frog and the four cars, once per frame
// The tick is delayed one cycle so the test sees the cars after their move
// No wrap-around, a car partly past the right edge counts only at its stored X
// o_Hit is a registered pulse, one cycle after the sampled tick
`timescale 1ns/1ps

module collisionDetector
(
    input  logic                       i_Clk,
    input  logic                       i_rstN,
    input  logic                       i_FrameTick,
    input  frogGeometryPkg::carLanes_t i_Cars,
    input  frogGeometryPkg::frogPos_t  i_Frog,
    output logic                       o_Hit
);

    import frogGeometryPkg::*;

    // One extra bit keeps the edge sums clear of overflow
    localparam logic [10:0] TileWide = 11'(TileSize);

    logic                 checkEn;
    xPos_t                carX    [LaneCount];
    logic [LaneCount-1:0] laneHit;
    logic                 anyHit;

    // Unpack the car bus into an indexable array
    assign carX[0] = i_Cars.carX0;
    assign carX[1] = i_Cars.carX1;
    assign carX[2] = i_Cars.carX2;
    assign carX[3] = i_Cars.carX3;

    ////////////////////////////////////////////////////////////
    // Per-lane overlap
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        for (int l = 0; l < LaneCount; l++)
        begin
            // Frog row must lie inside the lane band, and the two X spans must overlap
            laneHit[l] = ({2'b00, i_Frog.y} >= {2'b00, LaneRow[l]})
                      && ({2'b00, i_Frog.y} < ({2'b00, LaneRow[l]} + TileWide))
                      && ({1'b0, i_Frog.x} < ({1'b0, carX[l]} + TileWide))
                      && (({1'b0, i_Frog.x} + TileWide) > {1'b0, carX[l]});
        end
    end

    assign anyHit = |laneHit;

    ////////////////////////////////////////////////////////////
    // Check enable and hit pulse
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_rstN)
    begin
        if (!i_rstN)
        begin
            checkEn <= 1'b0;
            o_Hit   <= 1'b0;
        end
        else
        begin
            checkEn <= i_FrameTick;
            // Ticks are at least 4 cycles apart, so this is always a single pulse
            o_Hit   <= checkEn && anyHit;
        end
    end

endmodule

// File: source/frogControl.sv
// Frog position, lives, score and game over
// A hit wins over everything, then the goal respawn, then a move
// Moves that would leave the screen are dropped, not clamped to the edge
// Once gameOver is set the frog and status stay frozen until reset
`timescale 1ns/1ps

module frogControl
(
    input  logic                       i_Clk,
    input  logic                       i_rstN,
    input  frogGamePkg::moveCmd_t      i_Move,
    input  logic                       i_Hit,
    output frogGeometryPkg::frogPos_t  o_Frog,
    output frogGamePkg::gameStatus_t   o_Status
);

    import frogGeometryPkg::*;
    import frogGamePkg::*;

    localparam frogPos_t StartPos = '{x: xPos_t'(FrogStartX), y: yPos_t'(FrogStartY)};

    frogPos_t    frogPos;
    frogPos_t    stepPos;
    logic        stepValid;
    gameStatus_t status;

    ////////////////////////////////////////////////////////////
    // Candidate move
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        stepPos   = frogPos;
        stepValid = 1'b0;
        // Only the highest priority command counts, even when it is blocked
        if (i_Move.up)
        begin
            stepPos.y = frogPos.y - yPos_t'(TileSize);
            stepValid = frogPos.y >= yPos_t'(TileSize);
        end
        else if (i_Move.down)
        begin
            stepPos.y = frogPos.y + yPos_t'(TileSize);
            stepValid = frogPos.y < yPos_t'(ScreenHeight - TileSize);
        end
        else if (i_Move.left)
        begin
            stepPos.x = frogPos.x - xPos_t'(TileSize);
            stepValid = frogPos.x >= xPos_t'(TileSize);
        end
        else if (i_Move.right)
        begin
            stepPos.x = frogPos.x + xPos_t'(TileSize);
            stepValid = frogPos.x < xPos_t'(ScreenWidth - TileSize);
        end
    end

    ////////////////////////////////////////////////////////////
    // Frog and status registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge i_Clk or negedge i_rstN)
    begin
        if (!i_rstN)
        begin
            frogPos <= StartPos;
            status  <= '{lives: livesCount_t'(StartLives), score: '0, gameOver: 1'b0};
        end
        else if (!status.gameOver)
        begin
            if (i_Hit)
            begin
                // Respawn and lose a life, the last life ends the game
                frogPos      <= StartPos;
                status.lives <= status.lives - 1'b1;
                if (status.lives == livesCount_t'(1))
                begin
                    status.gameOver <= 1'b1;
                end
            end
            else if (frogPos.y == yPos_t'(GoalY))
            begin
                // The frog sat on the goal row for one cycle
                frogPos      <= StartPos;
                status.score <= status.score + 1'b1;
            end
            else if (stepValid)
            begin
                frogPos <= stepPos;
            end
        end
    end

    assign o_Frog   = frogPos;
    assign o_Status = status;

endmodule

// File: source/frogGamePkg.sv
// Game rules shared by the frog controller, the top level and the testbench
// Move commands are one-cycle pulses, up beats down, left and right
// Score is 8 bits and wraps silently, lives count down from StartLives
package frogGamePkg;

    ////////////////////////////////////////////////////////////
    // Button input
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } moveCmd_t;

    ////////////////////////////////////////////////////////////
    // Lives, score and status
    ////////////////////////////////////////////////////////////
    localparam int unsigned StartLives = 3;

    typedef logic [1:0] livesCount_t;
    typedef logic [7:0] scoreCount_t;

    // Status word for the renderer, 11 bits
    typedef struct packed {
        livesCount_t lives;
        scoreCount_t score;
        logic        gameOver;
    } gameStatus_t;

    // Frog spawns at the bottom row, middle column
    localparam int unsigned FrogStartX = 320;
    localparam int unsigned FrogStartY = 448;

    // Row that scores a point when reached
    localparam int unsigned GoalY = 0;

endpackage

// File: source/frogGameTop.sv
// Game core top level, wiring only
// Drives positions and status for an external renderer
// i_FrameTick and i_Move are one-cycle strobes from outside, no handshake
`timescale 1ns/1ps

module frogGameTop
(
    input  logic                       i_Clk,
    input  logic                       i_rstN,
    input  logic                       i_FrameTick,
    input  frogGamePkg::moveCmd_t      i_Move,
    output frogGeometryPkg::carLanes_t o_Cars,
    output frogGeometryPkg::frogPos_t  o_Frog,
    output logic                       o_Hit,
    output frogGamePkg::gameStatus_t   o_Status
);

    import frogGeometryPkg::*;

    // Internal buses shared between the three blocks
    carLanes_t carBus;
    frogPos_t  frogBus;
    logic      hitPulse;

    // Producer of the per-frame car positions
    carTraffic uTraffic
    (
        .i_Clk       (i_Clk),
        .i_rstN      (i_rstN),
        .i_FrameTick (i_FrameTick),
        .o_Cars      (carBus)
    );

    // Checks the frog against the cars one cycle after each tick
    collisionDetector uDetector
    (
        .i_Clk       (i_Clk),
        .i_rstN      (i_rstN),
        .i_FrameTick (i_FrameTick),
        .i_Cars      (carBus),
        .i_Frog      (frogBus),
        .o_Hit       (hitPulse)
    );

    // Moves the frog and keeps lives and score
    frogControl uFrog
    (
        .i_Clk    (i_Clk),
        .i_rstN   (i_rstN),
        .i_Move   (i_Move),
        .i_Hit    (hitPulse),
        .o_Frog   (frogBus),
        .o_Status (o_Status)
    );

    assign o_Cars = carBus;
    assign o_Frog = frogBus;
    assign o_Hit  = hitPulse;

endmodule

// File: source/frogGeometryPkg.sv
// Screen, tile and lane geometry shared by traffic, collision and frog logic
// Every position is the top-left pixel of one TileSize square object
// X fits 10 bits and Y fits 9 bits for a 640 x 480 screen
// Lane rows and speeds are fixed at build time, one entry per car lane
package frogGeometryPkg;

    ////////////////////////////////////////////////////////////
    // Screen and tile size
    ////////////////////////////////////////////////////////////
    localparam int unsigned ScreenWidth  = 640;
    localparam int unsigned ScreenHeight = 480;
    localparam int unsigned TileSize     = 32;
    localparam int unsigned LaneCount    = 4;

    ////////////////////////////////////////////////////////////
    // Position types
    ////////////////////////////////////////////////////////////
    typedef logic [9:0] xPos_t;
    typedef logic [8:0] yPos_t;

    // Frog tile corner, x in the upper bits
    typedef struct packed {
        xPos_t x;
        yPos_t y;
    } frogPos_t;

    // One X per lane, lane 0 in the upper bits
    typedef struct packed {
        xPos_t carX0;
        xPos_t carX1;
        xPos_t carX2;
        xPos_t carX3;
    } carLanes_t;

    ////////////////////////////////////////////////////////////
    // Per-lane constants
    ////////////////////////////////////////////////////////////
    // Y pixel of the top edge of each car lane
    localparam yPos_t LaneRow [LaneCount] = '{9'd128, 9'd192, 9'd256, 9'd320};

    // Pixels moved per frame tick
    localparam xPos_t LaneSpeed [LaneCount] = '{10'd2, 10'd3, 10'd4, 10'd5};

    // Staggered X position loaded on reset
    localparam xPos_t CarStartX [LaneCount] = '{10'd0, 10'd160, 10'd320, 10'd480};

endpackage

// File: test/collisionDetector_asserts.sv
// Timing checks on the collision detector's hit pulse, bound to every instance
// Sampled on the rising clock edge, so a tick seen at edge T shows as a hit at T+2 here
// failCount holds the number of failed assertions
`timescale 1ns/1ps

module collisionDetector_asserts
(
    input logic i_Clk,
    input logic i_rstN,
    input logic i_FrameTick,
    input logic i_Hit
);

    int unsigned failCount = 0;

    // The hit is a single-cycle pulse
    hitSingle: assert property (@(posedge i_Clk) disable iff (!i_rstN) i_Hit |=> !i_Hit)
    else
    begin
        failCount++;
        $error("o_Hit was high for two cycles in a row");
    end

    // A hit only rises right after the registered tick
    hitAfterTick: assert property (@(posedge i_Clk) disable iff (!i_rstN)
        $rose(i_Hit) |-> $past(i_FrameTick, 2))
    else
    begin
        failCount++;
        $error("o_Hit rose without a frame tick one cycle earlier");
    end

    // No hit while reset is held
    hitInReset: assert property (@(posedge i_Clk) !i_rstN |-> !i_Hit)
    else
    begin
        failCount++;
        $error("o_Hit was high during reset");
    end

endmodule

bind collisionDetector collisionDetector_asserts uAsserts
(
    .i_Clk       (i_Clk),
    .i_rstN      (i_rstN),
    .i_FrameTick (i_FrameTick),
    .i_Hit       (o_Hit)
);

// File: test/frogGameTb.sv
// Testbench for frogGameTop with seeded random frame ticks and move pulses
// A cycle model predicts every output and is compared on each falling edge
// Tests 4 and 5 depend on random hits, so their frame counts are upper bounds
`timescale 1ns/1ps

module frogGameTb;

    import frogGeometryPkg::*;
    import frogGamePkg::*;

    localparam int unsigned MotionFrames   = 200;
    localparam int unsigned MoveFrames     = 150;
    localparam int unsigned HitFrames      = 900;
    localparam int unsigned GameOverFrames = 40;
    // Each frame takes at most 8 cycles and both hit tests may run to their cap
    localparam int unsigned TestCycles =
        8 * (MotionFrames + MoveFrames + 2 * HitFrames + GameOverFrames) + 40;
    localparam frogPos_t StartPos = '{x: xPos_t'(FrogStartX), y: yPos_t'(FrogStartY)};

    logic        i_Clk = 1'b0;
    logic        i_rstN;
    logic        i_FrameTick;
    moveCmd_t    i_Move;
    carLanes_t   o_Cars;
    frogPos_t    o_Frog;
    logic        o_Hit;
    gameStatus_t o_Status;

    // Model state, updated on every rising edge
    xPos_t       mCarX [LaneCount];
    frogPos_t    mFrog;
    gameStatus_t mStatus;
    logic        mHit;
    logic        mCheckEn;
    int unsigned hitCount;
    int unsigned goalCount;
    int unsigned passCount = 0;
    int unsigned failCount = 0;

    frogGameTop dut (.*);

    always #4 i_Clk = ~i_Clk;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    task automatic resetModel();
        mCarX     = '{10'd0, 10'd160, 10'd320, 10'd480};
        mFrog     = StartPos;
        mStatus   = '{lives: livesCount_t'(StartLives), score: 8'd0, gameOver: 1'b0};
        mHit      = 1'b0;
        mCheckEn  = 1'b0;
        hitCount  = 0;
        goalCount = 0;
    endtask

    task automatic stepModel(input logic tick, input moveCmd_t mv);
        int   ts;
        int   fx;
        int   fy;
        int   sum;
        logic newHit;
        ts     = int'(TileSize);
        fx     = int'(mFrog.x);
        fy     = int'(mFrog.y);
        newHit = 1'b0;
        // The frog box is tested against each car box with values from before this edge
        for (int l = 0; l < LaneCount; l++)
            newHit |= mCheckEn && fy >= int'(LaneRow[l]) && fy < int'(LaneRow[l]) + ts
                      && fx < int'(mCarX[l]) + ts && fx + ts > int'(mCarX[l]);
        if (!mStatus.gameOver && mHit)
        begin
            mFrog         = StartPos;
            mStatus.lives = mStatus.lives - 2'd1;
            mStatus.gameOver = (mStatus.lives == 2'd0);
            hitCount++;
        end
        else if (!mStatus.gameOver && mFrog.y == yPos_t'(GoalY))
        begin
            mFrog         = StartPos;
            mStatus.score = mStatus.score + 8'd1;
            goalCount++;
        end
        else if (!mStatus.gameOver)
        begin
            // Only the highest priority bit counts, even when its step is off screen
            if (mv.up)
                fy = fy - ts;
            else if (mv.down)
                fy = fy + ts;
            else if (mv.left)
                fx = fx - ts;
            else if (mv.right)
                fx = fx + ts;
            if (fx >= 0 && fx <= int'(ScreenWidth) - ts
                && fy >= 0 && fy <= int'(ScreenHeight) - ts)
                mFrog = '{x: xPos_t'(fx), y: yPos_t'(fy)};
        end
        for (int l = 0; l < LaneCount; l++)
        begin
            sum = int'(mCarX[l]) + int'(LaneSpeed[l]);
            if (tick)
                mCarX[l] = xPos_t'(sum >= int'(ScreenWidth) ? sum - int'(ScreenWidth) : sum);
        end
        mHit     = newHit;
        mCheckEn = tick;
    endtask

    always @(posedge i_Clk or negedge i_rstN)
    begin
        if (!i_rstN)
            resetModel();
        else
            stepModel(i_FrameTick, i_Move);
    end

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic tally(input logic ok, input string name, input logic [39:0] expVal,
                         input logic [39:0] actVal);
        if (ok)
            passCount++;
        else
        begin
            failCount++;
            $display("[ERROR] %s expected %h actual %h at %0t", name, expVal, actVal, $time);
        end
    endtask

    task automatic checkCars(input carLanes_t expVal, input carLanes_t actVal);
        tally(actVal === expVal, "o_Cars", expVal, actVal);
    endtask

    task automatic checkFrog(input frogPos_t expVal, input frogPos_t actVal);
        tally(actVal === expVal, "o_Frog", expVal, actVal);
    endtask

    task automatic checkHit(input logic expVal, input logic actVal);
        tally(actVal === expVal, "o_Hit", expVal, actVal);
    endtask

    task automatic checkStatus(input gameStatus_t expVal, input gameStatus_t actVal);
        tally(actVal === expVal, "o_Status", expVal, actVal);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge i_Clk)
    begin
        checkCars('{carX0: mCarX[0], carX1: mCarX[1], carX2: mCarX[2], carX3: mCarX[3]}, o_Cars);
        checkFrog(mFrog, o_Frog);
        checkHit(mHit, o_Hit);
        checkStatus(mStatus, o_Status);
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    function automatic moveCmd_t pickMove(input int unsigned moveChance);
        logic [3:0] bits;
        bits = 4'b0000;
        // Half of all moves go up, one in eight sets several bits at once
        if ($urandom % 100 < moveChance)
        begin
            case ($urandom % 8)
                0, 1, 2, 3: bits = 4'b1000;
                4:          bits = 4'b0100;
                5:          bits = 4'b0010;
                6:          bits = 4'b0001;
                default:    bits = 4'($urandom);
            endcase
        end
        return moveCmd_t'(bits);
    endfunction

    // One tick, then 3 to 7 cycles of moves; the edge two after the tick gets none
    task automatic runFrame(input int unsigned moveChance);
        int unsigned gap;
        gap = 4 + $urandom % 5;
        @(posedge i_Clk);
        i_FrameTick <= 1'b1;
        i_Move      <= '0;
        for (int c = 1; c < gap; c++)
        begin
            @(posedge i_Clk);
            i_FrameTick <= 1'b0;
            i_Move      <= (c == 2) ? moveCmd_t'(4'b0000) : pickMove(moveChance);
        end
    endtask

    task automatic applyReset();
        @(posedge i_Clk);
        i_rstN      <= 1'b0;
        i_FrameTick <= 1'b0;
        i_Move      <= '0;
        repeat (8) @(posedge i_Clk);
        i_rstN <= 1'b1;
    endtask

    task automatic finishTest(input string name, input int unsigned failsBefore,
                              input logic goalMet, input string missing);
        if (!goalMet)
        begin
            failCount++;
            $display("Test %s: %s", name, missing);
        end
        $display("Test %s: %s with %0d errors", name,
                 (failCount == failsBefore) ? "passed" : "failed", failCount - failsBefore);
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        int unsigned fails;
        void'($urandom(47019));
        i_rstN      = 1'b0;
        i_FrameTick = 1'b0;
        i_Move      = '0;
        resetModel();

        // Reset values are compared on every falling edge by the checker
        fails = failCount;
        repeat (8) @(posedge i_Clk);
        i_rstN <= 1'b1;
        repeat (2) @(negedge i_Clk);
        finishTest("reset values", fails, 1'b1, "");

        fails = failCount;
        repeat (MotionFrames) runFrame(0);
        finishTest("car motion", fails, 1'b1, "");

        fails = failCount;
        repeat (MoveFrames) runFrame(70);
        finishTest("frog moves", fails, goalCount > 0, "the frog never reached the goal row");

        // With few moves the frog lingers inside the lanes
        applyReset();
        fails = failCount;
        for (int f = 0; f < HitFrames && hitCount == 0; f++)
            runFrame(25);
        finishTest("collisions", fails, hitCount > 0, "no collision happened");

        fails = failCount;
        for (int f = 0; f < HitFrames && !mStatus.gameOver; f++)
            runFrame(25);
        // Moves after game over must leave frog and status alone
        repeat (GameOverFrames) runFrame(70);
        finishTest("game over", fails, mStatus.gameOver,
                   "game over was not reached after three hits");

        @(negedge i_Clk);
        fails = dut.uDetector.uAsserts.failCount;
        $display("Checks passed: %0d, checks failed: %0d, assertion failures: %0d",
                 passCount, failCount, fails);
        if (failCount == 0 && fails == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    // The watchdog allows twice the longest possible run
    initial
    begin
        #(TestCycles * 8 * 2);
        $display("Timeout: the tests did not finish within %0d ns", TestCycles * 16);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: vlog.f
source/frogGeometryPkg.sv
source/frogGamePkg.sv
source/carTraffic.sv
source/collisionDetector.sv
source/frogControl.sv
source/frogGameTop.sv
test/collisionDetector_asserts.sv
test/frogGameTb.sv
